/* common/uart_alu_params.svh */
`ifndef UART_ALU_PARAMS_SVH
`define UART_ALU_PARAMS_SVH

////////////////////////////////////////
// serial frame format
////////////////////////////////////////

// data bits per character
`define UART_DBIT 8

// sample ticks in the stop interval
// 16/24/32 for 1/1.5/2 stop bits
`define UART_SB_TICK 16

////////////////////////////////////////
// baud rate
////////////////////////////////////////

// clock cycles per sample tick, 16 ticks per bit
// 10 cycles here, so one bit is 160 clocks
`define UART_BAUD_DIV 10

// width of the baud counter
`define UART_BAUD_DIV_BITS 8

////////////////////////////////////////
// alu
////////////////////////////////////////

// opcode field in the low bits of the opcode byte
`define ALU_NB_OP 6

`endif

/* common/uart_alu_pkg.sv */
`default_nettype none

`include "uart_alu_params.svh"

package uart_alu_pkg;

   // one byte on the serial line
   typedef logic [`UART_DBIT-1:0] data_t;

   // alu opcodes, mips funct style encoding
   typedef enum logic [`ALU_NB_OP-1:0] {
      OP_ADD = 6'b100000,
      OP_SUB = 6'b100010,
      OP_AND = 6'b100100,
      OP_OR  = 6'b100101,
      OP_XOR = 6'b100110,
      OP_NOR = 6'b100111,
      // shifts move A by the low bits of B
      OP_SRA = 6'b000011,
      OP_SRL = 6'b000010
   } alu_op_e;

endpackage

`default_nettype wire

/* uart/baud_rate_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_alu_params.svh"

module baud_rate_gen (
   input  wire logic i_clk,
   input  wire logic i_rst_n,
   output logic      o_tick
);

   localparam int CW = `UART_BAUD_DIV_BITS;
   // terminal count of the divider
   localparam logic [CW-1:0] LAST = CW'(`UART_BAUD_DIV - 1);

   logic [CW-1:0] cnt_reg;

   // free running mod-N counter
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         cnt_reg <= '0;
      end else if (cnt_reg == LAST) begin
         cnt_reg <= '0;
      end else begin
         cnt_reg <= cnt_reg + 1'b1;
      end
   end

   // one cycle strobe at terminal count
   // 16x the bit rate, shared by rx and tx
   assign o_tick = (cnt_reg == LAST);

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_alu_params.svh"

module uart_rx (
   input  wire logic                i_clk,
   input  wire logic                i_rst_n,
   input  wire logic                i_rx,
   input  wire logic                i_s_tick,
   output logic                     o_rx_done_tick,
   output uart_alu_pkg::data_t      o_data
);

   import uart_alu_pkg::*;

   ////////////////////////////////////////
   // constants
   ////////////////////////////////////////

   // samples per bit
   localparam int OVS = 16;
   // tick counter must hold the longer of a bit and the stop interval
   localparam int TW  = $clog2((`UART_SB_TICK > OVS) ? `UART_SB_TICK : OVS);
   localparam int NW  = $clog2(`UART_DBIT);

   localparam logic [TW-1:0] MID_TICK  = TW'(OVS / 2 - 1);
   localparam logic [TW-1:0] BIT_LAST  = TW'(OVS - 1);
   localparam logic [TW-1:0] STOP_LAST = TW'(`UART_SB_TICK - 1);
   localparam logic [NW-1:0] DBIT_LAST = NW'(`UART_DBIT - 1);

   // fsm encoding
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_START = 2'd1;
   localparam logic [1:0] ST_DATA  = 2'd2;
   localparam logic [1:0] ST_STOP  = 2'd3;

   logic          rx_meta;
   logic          rx_sync;
   logic [1:0]    state_reg;
   logic [1:0]    state_next;
   logic [TW-1:0] s_reg;
   logic [TW-1:0] s_next;
   logic [NW-1:0] n_reg;
   logic [NW-1:0] n_next;
   data_t         b_reg;
   data_t         b_next;

   ////////////////////////////////////////
   // registers
   ////////////////////////////////////////

   // two flop sync on the async line, idles high
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         rx_meta   <= 1'b1;
         rx_sync   <= 1'b1;
         state_reg <= ST_IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
      end else begin
         rx_meta   <= i_rx;
         rx_sync   <= rx_meta;
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end
   end

   // shift register, payload only
   always_ff @(posedge i_clk) begin
      b_reg <= b_next;
   end

   ////////////////////////////////////////
   // next state
   ////////////////////////////////////////

   always_comb begin
      state_next     = state_reg;
      s_next         = s_reg;
      n_next         = n_reg;
      b_next         = b_reg;
      o_rx_done_tick = 1'b0;
      case (state_reg)
         ST_IDLE: begin
            // falling edge marks a start bit
            if (!rx_sync) begin
               state_next = ST_START;
               s_next     = '0;
            end
         end
         ST_START: begin
            if (i_s_tick) begin
               if (s_reg == MID_TICK) begin
                  // still low at mid-bit, otherwise a glitch
                  state_next = rx_sync ? ST_IDLE : ST_DATA;
                  s_next     = '0;
                  n_next     = '0;
               end else begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         ST_DATA: begin
            if (i_s_tick) begin
               if (s_reg == BIT_LAST) begin
                  // bit centre, lsb arrives first
                  s_next = '0;
                  b_next = {rx_sync, b_reg[`UART_DBIT-1:1]};
                  if (n_reg == DBIT_LAST) begin
                     state_next = ST_STOP;
                  end else begin
                     n_next = n_reg + 1'b1;
                  end
               end else begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         ST_STOP: begin
            if (i_s_tick) begin
               if (s_reg == STOP_LAST) begin
                  state_next     = ST_IDLE;
                  o_rx_done_tick = 1'b1;
               end else begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

   // byte holds until the next frame shifts in
   assign o_data = b_reg;

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_alu_params.svh"

module uart_tx (
   input  wire logic                i_clk,
   input  wire logic                i_rst_n,
   input  wire logic                i_tx_start,
   input  wire logic                i_s_tick,
   input  wire uart_alu_pkg::data_t i_din,
   output logic                     o_tx_done_tick,
   output logic                     o_tx
);

   import uart_alu_pkg::*;

   // samples per bit, same grid as the receiver
   localparam int OVS = 16;
   localparam int TW  = $clog2((`UART_SB_TICK > OVS) ? `UART_SB_TICK : OVS);
   localparam int NW  = $clog2(`UART_DBIT);

   localparam logic [TW-1:0] BIT_LAST  = TW'(OVS - 1);
   localparam logic [TW-1:0] STOP_LAST = TW'(`UART_SB_TICK - 1);
   localparam logic [NW-1:0] DBIT_LAST = NW'(`UART_DBIT - 1);

   ////////////////////////////////////////
   // fsm encoding
   ////////////////////////////////////////

   localparam logic [2:0] ST_IDLE  = 3'd0;
   // byte taken, waiting for the tick grid
   localparam logic [2:0] ST_SYNC  = 3'd1;
   localparam logic [2:0] ST_START = 3'd2;
   localparam logic [2:0] ST_DATA  = 3'd3;
   localparam logic [2:0] ST_STOP  = 3'd4;

   logic [2:0]    state_reg;
   logic [2:0]    state_next;
   logic [TW-1:0] s_reg;
   logic [TW-1:0] s_next;
   logic [NW-1:0] n_reg;
   logic [NW-1:0] n_next;
   data_t         b_reg;
   data_t         b_next;
   logic          tx_reg;
   logic          tx_next;

   // control, line resets to idle high
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_reg <= ST_IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;
      end else begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end
   end

   always_ff @(posedge i_clk) begin
      b_reg <= b_next;
   end

   always_comb begin
      state_next     = state_reg;
      s_next         = s_reg;
      n_next         = n_reg;
      b_next         = b_reg;
      tx_next        = tx_reg;
      o_tx_done_tick = 1'b0;
      case (state_reg)
         ST_IDLE: begin
            tx_next = 1'b1;
            // start pulses outside idle are dropped
            if (i_tx_start) begin
               state_next = ST_SYNC;
               b_next     = i_din;
            end
         end
         ST_SYNC: begin
            tx_next = 1'b1;
            // start bit opens on a tick
            if (i_s_tick) begin
               state_next = ST_START;
               s_next     = '0;
               tx_next    = 1'b0;
            end
         end
         ST_START: begin
            tx_next = 1'b0;
            if (i_s_tick) begin
               if (s_reg == BIT_LAST) begin
                  state_next = ST_DATA;
                  s_next     = '0;
                  n_next     = '0;
                  tx_next    = b_reg[0];
               end else begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         ST_DATA: begin
            tx_next = b_reg[0];
            if (i_s_tick) begin
               if (s_reg == BIT_LAST) begin
                  s_next = '0;
                  // next bit into position 0
                  b_next = b_reg >> 1;
                  if (n_reg == DBIT_LAST) begin
                     state_next = ST_STOP;
                     tx_next    = 1'b1;
                  end else begin
                     n_next  = n_reg + 1'b1;
                     tx_next = b_reg[1];
                  end
               end else begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         ST_STOP: begin
            tx_next = 1'b1;
            if (i_s_tick) begin
               if (s_reg == STOP_LAST) begin
                  state_next     = ST_IDLE;
                  o_tx_done_tick = 1'b1;
               end else begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

   // registered line driver, no glitches
   assign o_tx = tx_reg;

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_alu_params.svh"

module alu (
   input  wire uart_alu_pkg::data_t   i_data_a,
   input  wire uart_alu_pkg::data_t   i_data_b,
   input  wire uart_alu_pkg::alu_op_e i_op,
   output uart_alu_pkg::data_t        o_result
);

   import uart_alu_pkg::*;

   // shift amount comes from the low bits of B
   localparam int SHW = $clog2(`UART_DBIT);

   logic [SHW-1:0] shamt;

   assign shamt = i_data_b[SHW-1:0];

   ////////////////////////////////////////
   // operation select
   ////////////////////////////////////////

   always_comb begin
      case (i_op)
         // add and sub wrap, no carry out
         OP_ADD:  o_result = i_data_a + i_data_b;
         OP_SUB:  o_result = i_data_a - i_data_b;
         OP_AND:  o_result = i_data_a & i_data_b;
         OP_OR:   o_result = i_data_a | i_data_b;
         OP_XOR:  o_result = i_data_a ^ i_data_b;
         OP_NOR:  o_result = ~(i_data_a | i_data_b);
         // sign bit fills from the left
         OP_SRA:  o_result = data_t'($signed(i_data_a) >>> shamt);
         OP_SRL:  o_result = i_data_a >> shamt;
         // unknown opcode
         default: o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* design/interface_circuit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_alu_params.svh"

module interface_circuit (
   input  wire logic                i_clk,
   input  wire logic                i_rst_n,
   input  wire logic                i_rx_done_tick,
   input  wire uart_alu_pkg::data_t i_rx_data,
   input  wire uart_alu_pkg::data_t i_alu_result,
   output logic                     o_tx_start,
   output uart_alu_pkg::data_t      o_data_a,
   output uart_alu_pkg::data_t      o_data_b,
   output uart_alu_pkg::data_t      o_tx_data,
   output uart_alu_pkg::alu_op_e    o_op
);

   import uart_alu_pkg::*;

   // which byte of the frame comes next
   localparam logic [1:0] ST_A  = 2'd0;
   localparam logic [1:0] ST_B  = 2'd1;
   localparam logic [1:0] ST_OP = 2'd2;

   logic [1:0] state_reg;
   logic       tx_start_reg;
   data_t      data_a_reg;
   data_t      data_b_reg;
   data_t      result_reg;
   alu_op_e    op_reg;
   alu_op_e    rx_op;

   // opcode field of the incoming byte, top bits dropped
   assign rx_op = alu_op_e'(i_rx_data[`ALU_NB_OP-1:0]);

   ////////////////////////////////////////
   // byte sequencer
   ////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_reg    <= ST_A;
         tx_start_reg <= 1'b0;
      end else begin
         // single cycle strobe
         tx_start_reg <= 1'b0;
         if (i_rx_done_tick) begin
            case (state_reg)
               ST_A:    state_reg <= ST_B;
               ST_B:    state_reg <= ST_OP;
               ST_OP: begin
                  state_reg    <= ST_A;
                  tx_start_reg <= 1'b1;
               end
               default: state_reg <= ST_A;
            endcase
         end
      end
   end

   // operand and result capture
   always_ff @(posedge i_clk) begin
      if (i_rx_done_tick) begin
         case (state_reg)
            ST_A: data_a_reg <= i_rx_data;
            ST_B: data_b_reg <= i_rx_data;
            ST_OP: begin
               op_reg     <= rx_op;
               // alu already sees the new opcode this cycle
               result_reg <= i_alu_result;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // outputs
   ////////////////////////////////////////

   // opcode byte goes straight to the alu while it is expected
   assign o_op       = (state_reg == ST_OP) ? rx_op : op_reg;
   assign o_data_a   = data_a_reg;
   assign o_data_b   = data_b_reg;
   assign o_tx_data  = result_reg;
   assign o_tx_start = tx_start_reg;

endmodule

`default_nettype wire

/* design/top_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module top_uart (
   input  wire logic i_clk,
   input  wire logic i_rst_n,
   input  wire logic i_rx,
   output logic      o_tx
);

   import uart_alu_pkg::*;

   logic    tick;
   // receiver strobe and byte
   logic    rx_done_tick;
   data_t   rx_data;
   // alu operands and result
   data_t   data_a;
   data_t   data_b;
   alu_op_e op;
   data_t   alu_result;
   // reply path to the transmitter
   logic    tx_start;
   data_t   tx_data;

   ////////////////////////////////////////
   // serial side
   ////////////////////////////////////////

   // 16x sample tick for both directions
   baud_rate_gen baud_rate_gen_inst (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .o_tick  (tick)
   );

   uart_rx uart_rx_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_rx           (i_rx),
      .i_s_tick       (tick),
      .o_rx_done_tick (rx_done_tick),
      .o_data         (rx_data)
   );

   // end of frame strobe has no user here, host paces the frames
   uart_tx uart_tx_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_tx_start     (tx_start),
      .i_s_tick       (tick),
      .i_din          (tx_data),
      .o_tx_done_tick (),
      .o_tx           (o_tx)
   );

   ////////////////////////////////////////
   // frame sequencer and alu
   ////////////////////////////////////////

   // three bytes in, one reply out
   interface_circuit interface_circuit_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_rx_done_tick (rx_done_tick),
      .i_rx_data      (rx_data),
      .i_alu_result   (alu_result),
      .o_tx_start     (tx_start),
      .o_data_a       (data_a),
      .o_data_b       (data_b),
      .o_tx_data      (tx_data),
      .o_op           (op)
   );

   alu alu_inst (
      .i_data_a (data_a),
      .i_data_b (data_b),
      .i_op     (op),
      .o_result (alu_result)
   );

endmodule

`default_nettype wire

/* tests/tb_top_uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_alu_params.svh"

module tb_top_uart;

   localparam int CLK_NS      = 4;
   // 16 sample ticks per bit
   localparam int BIT_CYC     = 16 * `UART_BAUD_DIV;
   localparam int REPLY_LIMIT = 12 * BIT_CYC;
   // frames over all tests, rounded up
   localparam int N_FRAMES    = 84;
   localparam longint WDOG_NS = longint'(N_FRAMES) * 4 * 10 * BIT_CYC * CLK_NS + 500_000;

   logic i_clk;
   logic i_rst_n;
   logic i_rx;
   logic o_tx;

   logic [7:0]  exp_q[$];
   logic [7:0]  act_q[$];
   int          sent_cnt    = 0;
   int          checked_cnt = 0;
   logic        idle_watch  = 1'b0;
   logic [31:0] lfsr_state  = 32'hd80a94db;
   event        reply_ev;

   top_uart top_uart_inst (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_rx    (i_rx),
      .o_tx    (o_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_NS / 2) i_clk = ~i_clk;
   end

   ////////////////////////////////////////
   // reporting
   ////////////////////////////////////////

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         report_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
      end
   endtask

   ////////////////////////////////////////
   // reference model and random source
   ////////////////////////////////////////

   // opcode from the low 6 bits, top two ignored
   function automatic logic [7:0] alu_ref(input logic [7:0] a, input logic [7:0] b,
                                          input logic [7:0] op_byte);
      logic [5:0]  op;
      logic [2:0]  sh;
      logic [15:0] ext;
      op  = op_byte[5:0];
      sh  = b[2:0];
      // sign extended copy for the arithmetic shift
      ext = {{8{a[7]}}, a} >> sh;
      case (op)
         6'b100000: alu_ref = a + b;
         6'b100010: alu_ref = a - b;
         6'b100100: alu_ref = a & b;
         6'b100101: alu_ref = a | b;
         6'b100110: alu_ref = a ^ b;
         6'b100111: alu_ref = ~(a | b);
         6'b000011: alu_ref = ext[7:0];
         6'b000010: alu_ref = a >> sh;
         default:   alu_ref = 8'h00;
      endcase
   endfunction

   // the eight defined opcodes by index
   function automatic logic [7:0] defined_op(input logic [2:0] idx);
      case (idx)
         3'd0:    defined_op = 8'h20;
         3'd1:    defined_op = 8'h22;
         3'd2:    defined_op = 8'h24;
         3'd3:    defined_op = 8'h25;
         3'd4:    defined_op = 8'h26;
         3'd5:    defined_op = 8'h27;
         3'd6:    defined_op = 8'h03;
         default: defined_op = 8'h02;
      endcase
   endfunction

   // right shifting galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[6:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      rand_bits = v;
   endfunction

   ////////////////////////////////////////
   // host side driver
   ////////////////////////////////////////

   task automatic apply_reset();
      @(posedge i_clk);
      i_rst_n <= 1'b0;
      repeat (4) @(posedge i_clk);
      i_rst_n <= 1'b1;
   endtask

   // start bit, data lsb first, stop bit
   task automatic send_byte(input logic [7:0] value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge i_clk);
         i_rx <= frame[i];
         repeat (BIT_CYC - 1) @(posedge i_clk);
      end
   endtask

   task automatic wait_reply();
      int cycles;
      cycles = 0;
      while (checked_cnt != sent_cnt && cycles <= REPLY_LIMIT) begin
         @(negedge i_clk);
         cycles++;
      end
      if (checked_cnt != sent_cnt) begin
         report_failure("timeout waiting for a reply frame on o_tx");
      end
   endtask

   // one frame, then hold until its reply is checked
   task automatic run_frame(input logic [7:0] a, input logic [7:0] b,
                            input logic [7:0] op_byte);
      send_byte(a);
      send_byte(b);
      exp_q.push_back(alu_ref(a, b, op_byte));
      sent_cnt++;
      // reply may start once the opcode byte is in
      idle_watch = 1'b0;
      send_byte(op_byte);
      wait_reply();
      // quiet line until the next opcode byte
      idle_watch = 1'b1;
   endtask

   task automatic run_all_ops(input logic [7:0] a, input logic [7:0] b);
      for (int i = 0; i < 8; i++) begin
         run_frame(a, b, defined_op(3'(i)));
      end
   endtask

   ////////////////////////////////////////
   // serial monitor and compare
   ////////////////////////////////////////

   // line must stay idle while no reply is due
   always @(negedge i_clk) begin
      if (idle_watch) begin
         check_value("o_tx idle", 32'h1, {31'b0, o_tx});
      end
   end

   initial begin : tx_monitor
      logic [7:0] byte_v;
      wait (i_rst_n === 1'b1);
      forever begin
         @(negedge o_tx);
         // centre of the start bit
         repeat (BIT_CYC / 2) @(negedge i_clk);
         if (o_tx !== 1'b0) begin
            report_failure("false start bit on o_tx, line high at mid bit");
         end else begin
            for (int k = 0; k < 8; k++) begin
               repeat (BIT_CYC) @(negedge i_clk);
               byte_v[k] = o_tx;
            end
            repeat (BIT_CYC) @(negedge i_clk);
            if (o_tx !== 1'b1) begin
               report_failure("framing error, stop bit of a reply frame is low");
            end else begin
               act_q.push_back(byte_v);
               -> reply_ev;
            end
         end
      end
   end

   initial begin : reply_checker
      logic [7:0] got;
      logic [7:0] want;
      forever begin
         @(reply_ev);
         while (act_q.size() > 0) begin
            got = act_q.pop_front();
            if (exp_q.size() == 0) begin
               report_failure("unexpected reply frame on o_tx");
            end else begin
               want = exp_q.pop_front();
               check_value("o_tx byte", {24'b0, want}, {24'b0, got});
               checked_cnt++;
            end
         end
      end
   end

   initial begin : watchdog
      #(WDOG_NS);
      report_failure("watchdog expired, the run took too long");
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin : main_seq
      logic [7:0] ra;
      logic [7:0] rb;
      logic [7:0] rop;
      i_rst_n = 1'b0;
      i_rx    = 1'b1;
      apply_reset();

      // quiet line after reset, also watched during the first frame
      idle_watch = 1'b1;
      repeat (2 * BIT_CYC) @(negedge i_clk);

      // every opcode on edge operands
      run_all_ops(8'h00, 8'hff);
      run_all_ops(8'hff, 8'h80);
      run_all_ops(8'h80, 8'h07);
      run_all_ops(8'h7f, 8'h01);

      // random frames from the defined set
      for (int i = 0; i < 40; i++) begin
         ra  = rand_bits(8);
         rb  = rand_bits(8);
         rop = defined_op(3'(rand_bits(3)));
         run_frame(ra, rb, rop);
      end

      // undefined codes give zero, top bits dropped
      run_frame(8'h9c, 8'h05, 8'h00);
      run_frame(8'h9c, 8'h05, 8'h01);
      run_frame(8'h9c, 8'h05, 8'h21);
      run_frame(8'h9c, 8'h05, 8'h3f);
      run_frame(8'h9c, 8'h05, 8'hff);
      run_frame(8'h9c, 8'h05, 8'h87);
      run_frame(8'h9c, 8'h05, 8'he0);
      run_frame(8'h9c, 8'h05, 8'h62);
      run_frame(8'h9c, 8'h05, 8'hc3);

      // partial frame then reset, sequencer back to A
      send_byte(8'h3c);
      apply_reset();
      run_frame(8'h81, 8'h02, 8'h03);

      // no stray reply after the last frame
      repeat (REPLY_LIMIT) @(negedge i_clk);
      if (exp_q.size() == 0 && checked_cnt == sent_cnt) begin
         $display("All tests passed!");
         $finish;
      end else begin
         report_failure("replies still missing at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/uart_alu_pkg.sv
uart/baud_rate_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/alu.sv
design/interface_circuit.sv
design/top_uart.sv
tests/tb_top_uart.sv
